//--- logic/dmem_pkg.sv
// sizes, access and command enums, request, result and memory structs
package dmem_pkg;

    localparam int rob_w    = 5;
    localparam int prf_w    = 6;
    localparam int sq_depth = 8;
    localparam int sq_cnt_w = 4;
    localparam int sq_ptr_w = 3;

    // 16-bit address split as tag | set index | byte offset
    localparam int addr_w   = 16;
    localparam int idx_w    = 5;
    localparam int tag_w    = 8;
    localparam int off_w    = 3;
    localparam int line_w   = tag_w + idx_w;
    localparam int num_sets = 1 << idx_w;

    typedef enum logic [1:0] {
        mem_byte,
        mem_half,
        mem_word,
        mem_double
    } mem_size_e;

    typedef enum logic [1:0] {
        cmd_none,
        cmd_load,
        cmd_store
    } mem_cmd_e;

    typedef struct packed {
        logic              valid;
        logic              is_load;
        logic [rob_w-1:0]  rob_idx;
        logic [prf_w-1:0]  prf_idx;
        logic [addr_w-1:0] addr;
        mem_size_e         size;
        logic              is_signed;
        logic [31:0]       data;
    } ls_req_t;

    typedef struct packed {
        logic             valid;
        logic [31:0]      data;
        logic [prf_w-1:0] prf_idx;
        logic [rob_w-1:0] rob_idx;
    } cdb_pkt_t;

    typedef struct packed {
        logic             en;
        logic [idx_w-1:0] idx;
        logic [tag_w-1:0] tag;
    } cache_rd_t;

    typedef struct packed {
        logic              en;
        logic [addr_w-1:0] addr;
        mem_size_e         size;
        logic [31:0]       data;
    } cache_wr_t;

    typedef struct packed {
        mem_cmd_e          cmd;
        logic [addr_w-1:0] addr;
        mem_size_e         size;
        logic [63:0]       data;
    } mem_req_t;

    // response tag 0 means the command was refused
    typedef struct packed {
        logic [3:0]  response;
        logic [3:0]  tag;
        logic [63:0] data;
    } mem_rsp_t;

endpackage

//--- logic/store_queue.sv
`timescale 1ns/1ns
// store queue: circular buffer with commit count, flush and line-conflict mask
module store_queue (
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic                              except,
    input  logic                              commit,
    input  dmem_pkg::ls_req_t                 st_req,
    input  logic                              wr_done,
    input  logic [dmem_pkg::line_w-1:0]       probe_line,
    output logic [dmem_pkg::sq_cnt_w-1:0]     num_free,
    output dmem_pkg::mem_req_t                wr_req,
    output dmem_pkg::cache_wr_t               cache_wr,
    output logic [dmem_pkg::sq_depth-1:0]     conflict_mask,
    output logic [dmem_pkg::sq_depth-1:0]     drained_mask
);

    dmem_pkg::ls_req_t                ents [dmem_pkg::sq_depth];
    dmem_pkg::ls_req_t                head_ent;
    logic [dmem_pkg::sq_ptr_w-1:0]    head, tail, head_n;
    logic [dmem_pkg::sq_cnt_w-1:0]    count, ncommit, ncommit_n;
    logic [dmem_pkg::sq_depth-1:0]    held;
    logic                             push, pop;

    assign push      = st_req.valid && !except;
    assign pop       = wr_done;
    assign head_n    = head + dmem_pkg::sq_ptr_w'(pop);
    assign ncommit_n = ncommit + dmem_pkg::sq_cnt_w'(commit) - dmem_pkg::sq_cnt_w'(pop);
    assign num_free  = dmem_pkg::sq_cnt_w'(dmem_pkg::sq_depth) - count;
    assign head_ent  = ents[head];

    // occupancy and line match per slot
    always_comb begin
        logic [dmem_pkg::sq_ptr_w-1:0] rel;
        for (int i = 0; i < dmem_pkg::sq_depth; i++) begin
            rel = dmem_pkg::sq_ptr_w'(i) - head;
            held[i] = {1'b0, rel} < count;
            conflict_mask[i] = held[i] && (ents[i].addr[dmem_pkg::addr_w-1:dmem_pkg::off_w]
                                           == probe_line);
        end
    end

    assign drained_mask = pop ? ({{(dmem_pkg::sq_depth-1){1'b0}}, 1'b1} << head) : '0;

    // oldest committed entry goes out to memory and cache
    always_comb begin
        wr_req.cmd    = (ncommit != '0) ? dmem_pkg::cmd_store : dmem_pkg::cmd_none;
        wr_req.addr   = head_ent.addr;
        wr_req.size   = head_ent.size;
        wr_req.data   = {32'b0, head_ent.data};
        cache_wr.en   = pop;
        cache_wr.addr = head_ent.addr;
        cache_wr.size = head_ent.size;
        cache_wr.data = head_ent.data;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            ncommit <= '0;
        end else begin
            head    <= head_n;
            ncommit <= ncommit_n;
            if (except) begin
                // keep only what the ROB already retired
                count <= ncommit_n;
                tail  <= head_n + ncommit_n[dmem_pkg::sq_ptr_w-1:0];
            end else begin
                count <= count + dmem_pkg::sq_cnt_w'(push) - dmem_pkg::sq_cnt_w'(pop);
                tail  <= tail + dmem_pkg::sq_ptr_w'(push);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            ents[tail] <= st_req;
        end
    end

    a_commit_held: assert property (@(posedge clock) disable iff (!rst_n)
        commit |-> ncommit < count);

    a_store_room: assert property (@(posedge clock) disable iff (!rst_n)
        st_req.valid |-> num_free != '0);

endmodule

//--- logic/load_unit.sv
`timescale 1ns/1ns
// load unit: single load holder with conflict wait, cache lookup, miss and result extend
module load_unit (
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic                              except,
    input  dmem_pkg::ls_req_t                 ld_req,
    input  logic [dmem_pkg::sq_depth-1:0]     conflict_mask,
    input  logic [dmem_pkg::sq_depth-1:0]     drained_mask,
    input  logic                              hit,
    input  logic [63:0]                       rd_line,
    input  logic                              fill_valid,
    input  logic [63:0]                       fill_line,
    output logic [dmem_pkg::line_w-1:0]       probe_line,
    output dmem_pkg::cache_rd_t               cache_rd,
    output logic                              miss_req,
    output logic                              num_free,
    output dmem_pkg::cdb_pkt_t                cdb_out
);

    typedef enum logic [2:0] {
        st_idle,
        st_wait_sq,
        st_lookup,
        st_miss,
        st_done
    } state_e;

    state_e                         state;
    dmem_pkg::ls_req_t              ent;
    logic [dmem_pkg::sq_depth-1:0]  mask;

    // pick addressed bytes out of the line, then extend by size
    function automatic logic [31:0] extend(input logic [63:0] line,
                                           input dmem_pkg::ls_req_t ld);
        logic [63:0] sh;
        sh = line >> {ld.addr[dmem_pkg::off_w-1:0], 3'b000};
        case (ld.size)
            dmem_pkg::mem_byte: extend = {{24{ld.is_signed & sh[7]}}, sh[7:0]};
            dmem_pkg::mem_half: extend = {{16{ld.is_signed & sh[15]}}, sh[15:0]};
            default:            extend = sh[31:0];
        endcase
    endfunction

    assign probe_line = ld_req.addr[dmem_pkg::addr_w-1:dmem_pkg::off_w];
    assign miss_req   = state == st_miss;
    assign num_free   = state == st_idle;

    // idle reads straight from the request so a clean hit takes two cycles
    always_comb begin
        cache_rd.en  = 1'b0;
        cache_rd.idx = ent.addr[dmem_pkg::off_w +: dmem_pkg::idx_w];
        cache_rd.tag = ent.addr[dmem_pkg::addr_w-1 -: dmem_pkg::tag_w];
        if (state == st_idle) begin
            cache_rd.en  = ld_req.valid && conflict_mask == '0;
            cache_rd.idx = ld_req.addr[dmem_pkg::off_w +: dmem_pkg::idx_w];
            cache_rd.tag = ld_req.addr[dmem_pkg::addr_w-1 -: dmem_pkg::tag_w];
        end else if (state == st_wait_sq) begin
            cache_rd.en = mask == '0;
        end
    end

    always_ff @(posedge clock) begin
        cdb_out.valid <= 1'b0;
        if (!rst_n || except) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (ld_req.valid) begin
                    ent   <= ld_req;
                    mask  <= conflict_mask & ~drained_mask;
                    state <= (conflict_mask == '0) ? st_lookup : st_wait_sq;
                end
                st_wait_sq: begin
                    mask <= mask & ~drained_mask;
                    if (mask == '0) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    state <= hit ? st_done : st_miss;
                    cdb_out <= '{valid: hit, data: extend(rd_line, ent),
                                 prf_idx: ent.prf_idx, rob_idx: ent.rob_idx};
                end
                st_miss: if (fill_valid) begin
                    state <= st_done;
                    cdb_out <= '{valid: 1'b1, data: extend(fill_line, ent),
                                 prf_idx: ent.prf_idx, rob_idx: ent.rob_idx};
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_load_room: assert property (@(posedge clock) disable iff (!rst_n)
        ld_req.valid |-> num_free);

endmodule

//--- logic/dcache.sv
`timescale 1ns/1ns
// data cache: direct-mapped valid, tag and line arrays with read, store and fill ports
module dcache (
    input  logic                              clock,
    input  logic                              rst_n,
    input  dmem_pkg::cache_rd_t               cache_rd,
    input  dmem_pkg::cache_wr_t               cache_wr,
    input  logic                              fill_valid,
    input  logic [dmem_pkg::line_w-1:0]       fill_addr,
    input  logic [63:0]                       fill_line,
    output logic                              hit,
    output logic [63:0]                       rd_line
);

    logic [dmem_pkg::tag_w-1:0]   tags  [dmem_pkg::num_sets];
    logic [63:0]                  lines [dmem_pkg::num_sets];
    logic [dmem_pkg::num_sets-1:0] valid;

    logic [dmem_pkg::idx_w-1:0]   wr_idx, fill_idx;
    logic [dmem_pkg::tag_w-1:0]   wr_tag, fill_tag;
    logic [dmem_pkg::off_w-1:0]   wr_off;
    logic [7:0]                   be_raw, wr_be;
    logic [63:0]                  wr_data;
    logic                         wr_hit;

    assign wr_idx   = cache_wr.addr[dmem_pkg::off_w +: dmem_pkg::idx_w];
    assign wr_tag   = cache_wr.addr[dmem_pkg::addr_w-1 -: dmem_pkg::tag_w];
    assign wr_off   = cache_wr.addr[dmem_pkg::off_w-1:0];
    assign fill_idx = fill_addr[dmem_pkg::idx_w-1:0];
    assign fill_tag = fill_addr[dmem_pkg::line_w-1:dmem_pkg::idx_w];

    // byte enables of a store within its line
    always_comb begin
        case (cache_wr.size)
            dmem_pkg::mem_byte: be_raw = 8'h01;
            dmem_pkg::mem_half: be_raw = 8'h03;
            dmem_pkg::mem_word: be_raw = 8'h0f;
            default:            be_raw = 8'hff;
        endcase
        wr_be   = be_raw << wr_off;
        wr_data = {32'b0, cache_wr.data} << {wr_off, 3'b000};
        wr_hit  = cache_wr.en && valid[wr_idx] && tags[wr_idx] == wr_tag;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            valid <= '0;
            hit   <= 1'b0;
        end else begin
            if (cache_rd.en) begin
                hit <= valid[cache_rd.idx] && tags[cache_rd.idx] == cache_rd.tag;
            end
            if (fill_valid) begin
                valid[fill_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (cache_rd.en) begin
            rd_line <= lines[cache_rd.idx];
        end
        // no write-allocate, so a store only touches a present line
        if (wr_hit) begin
            for (int b = 0; b < 8; b++) begin
                if (wr_be[b]) begin
                    lines[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
        // fill comes last and owns the whole line
        if (fill_valid) begin
            lines[fill_idx] <= fill_line;
            tags[fill_idx]  <= fill_tag;
        end
    end

endmodule

//--- logic/dcache_ctrl.sv
`timescale 1ns/1ns
// memory port controller with read/store arbitration and outstanding read tag tracking
module dcache_ctrl (
    input  logic                              clock,
    input  logic                              rst_n,
    input  dmem_pkg::mem_req_t                wr_req,
    input  logic                              miss_req,
    input  logic [dmem_pkg::line_w-1:0]       miss_addr,
    input  dmem_pkg::mem_rsp_t                mem2proc,
    output logic                              wr_done,
    output logic                              fill_valid,
    output logic [dmem_pkg::line_w-1:0]       fill_addr,
    output logic [63:0]                       fill_line,
    output dmem_pkg::mem_cmd_e                dmem_cmd,
    output logic [dmem_pkg::addr_w-1:0]       dmem_addr,
    output dmem_pkg::mem_size_e               dmem_size,
    output logic [63:0]                       dmem_data
);

    dmem_pkg::mem_req_t               sel;
    logic                             rd_pending;
    logic [3:0]                       rd_tag;
    logic [dmem_pkg::line_w-1:0]      rd_line;
    logic                             issue_rd, st_block, rd_accept;

    assign issue_rd = miss_req && !rd_pending;
    // hold a store to the line being fetched so the fill cannot bring stale bytes
    assign st_block = rd_pending && wr_req.addr[dmem_pkg::addr_w-1:dmem_pkg::off_w] == rd_line;

    always_comb begin
        sel = '{cmd: dmem_pkg::cmd_none, addr: '0, size: dmem_pkg::mem_byte, data: '0};
        if (issue_rd) begin
            sel.cmd  = dmem_pkg::cmd_load;
            sel.addr = {miss_addr, {dmem_pkg::off_w{1'b0}}};
            sel.size = dmem_pkg::mem_double;
        end else if (wr_req.cmd == dmem_pkg::cmd_store && !st_block) begin
            sel = wr_req;
        end
    end

    assign dmem_cmd  = sel.cmd;
    assign dmem_addr = sel.addr;
    assign dmem_size = sel.size;
    assign dmem_data = sel.data;

    assign wr_done    = sel.cmd == dmem_pkg::cmd_store && mem2proc.response != '0;
    assign rd_accept  = sel.cmd == dmem_pkg::cmd_load && mem2proc.response != '0;
    assign fill_valid = rd_pending && mem2proc.tag == rd_tag;
    assign fill_addr  = rd_line;
    assign fill_line  = mem2proc.data;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rd_pending <= 1'b0;
        end else if (rd_accept) begin
            rd_pending <= 1'b1;
        end else if (fill_valid) begin
            rd_pending <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_accept) begin
            rd_tag  <= mem2proc.response;
            rd_line <= miss_addr;
        end
    end

    // every data reply belongs to the single outstanding read
    a_one_read: assert property (@(posedge clock) disable iff (!rst_n)
        mem2proc.tag != '0 |-> rd_pending && mem2proc.tag == rd_tag);

endmodule

//--- logic/dmem.sv
`timescale 1ns/1ns
// data-memory top: store queue, load unit, data cache and memory controller
module dmem (
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic                              except,
    input  logic                              commit,
    input  dmem_pkg::ls_req_t                 req,
    input  dmem_pkg::mem_rsp_t                mem2proc,
    output logic [dmem_pkg::sq_cnt_w-1:0]     sq_num_free,
    output logic                              lq_num_free,
    output dmem_pkg::cdb_pkt_t                cdb_out,
    output dmem_pkg::mem_cmd_e                dmem_cmd,
    output logic [dmem_pkg::addr_w-1:0]       dmem_addr,
    output dmem_pkg::mem_size_e               dmem_size,
    output logic [63:0]                       dmem_data
);

    dmem_pkg::ls_req_t              st_req, ld_req;
    dmem_pkg::mem_req_t             wr_req;
    dmem_pkg::cache_wr_t            cache_wr;
    dmem_pkg::cache_rd_t            cache_rd;
    logic [dmem_pkg::line_w-1:0]    probe_line, miss_addr, fill_addr;
    logic [dmem_pkg::sq_depth-1:0]  conflict_mask, drained_mask;
    logic [63:0]                    rd_line, fill_line;
    logic                           wr_done, hit, miss_req, fill_valid, ld_fill;

    // loads to the load unit, stores to the queue
    always_comb begin
        st_req       = req;
        st_req.valid = req.valid && !req.is_load;
        ld_req       = req;
        ld_req.valid = req.valid && req.is_load;
    end

    assign miss_addr = {cache_rd.tag, cache_rd.idx};
    // a fill left over from a flushed load belongs only to the cache
    assign ld_fill   = fill_valid && fill_addr == miss_addr;

    store_queue u_sq (
        .clock, .rst_n, .except, .commit, .st_req, .wr_done, .probe_line,
        .num_free(sq_num_free), .wr_req, .cache_wr, .conflict_mask, .drained_mask
    );

    load_unit u_lu (
        .clock, .rst_n, .except, .ld_req, .conflict_mask, .drained_mask,
        .hit, .rd_line, .fill_valid(ld_fill), .fill_line,
        .probe_line, .cache_rd, .miss_req, .num_free(lq_num_free), .cdb_out
    );

    dcache u_dc (
        .clock, .rst_n, .cache_rd, .cache_wr, .fill_valid, .fill_addr, .fill_line,
        .hit, .rd_line
    );

    dcache_ctrl u_ctrl (
        .clock, .rst_n, .wr_req, .miss_req, .miss_addr, .mem2proc,
        .wr_done, .fill_valid, .fill_addr, .fill_line,
        .dmem_cmd, .dmem_addr, .dmem_size, .dmem_data
    );

endmodule

//--- sim/dmem_ref.svh
// reference model: byte image of memory, tagged memory responder and load predictor
logic [7:0]  img [65536];
logic [3:0]  next_tag;
logic        rd_busy;
int          rd_due;
logic [3:0]  rd_tag;
logic [63:0] rd_data;

// pattern depends on both address bytes
task automatic fill_image();
    for (int a = 0; a < 65536; a++) begin
        img[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
    end
endtask

function automatic logic [63:0] read_line(input logic [15:0] addr);
    logic [63:0] line;
    for (int i = 0; i < 8; i++) begin
        line[i*8 +: 8] = img[{addr[15:3], 3'(i)}];
    end
    return line;
endfunction

task automatic apply_store(input dmem_pkg::mem_req_t st);
    int n;
    n = 1 << int'(st.size);
    for (int i = 0; i < n; i++) begin
        img[st.addr + 16'(i)] = st.data[i*8 +: 8];
    end
endtask

// little-endian bytes at the load address, extended by size and signedness
function automatic logic [31:0] predict_load(input dmem_pkg::ls_req_t ld);
    logic [31:0] raw;
    for (int i = 0; i < 4; i++) begin
        raw[i*8 +: 8] = img[ld.addr + 16'(i)];
    end
    case (ld.size)
        dmem_pkg::mem_byte: return {{24{ld.is_signed & raw[7]}}, raw[7:0]};
        dmem_pkg::mem_half: return {{16{ld.is_signed & raw[15]}}, raw[15:0]};
        default:            return raw;
    endcase
endfunction

task automatic take_read(input logic [15:0] addr, input int now);
    rd_busy = 1'b1;
    rd_tag  = mem2proc.response;
    rd_data = read_line(addr);
    rd_due  = now + 1 + int'($urandom % 6);
endtask

// data reply when due, random refusal of the next command
task automatic respond_step(input int now);
    if (rd_busy && now >= rd_due) begin
        mem2proc.tag  <= rd_tag;
        mem2proc.data <= rd_data;
        rd_busy = 1'b0;
    end else begin
        mem2proc.tag  <= 4'd0;
        mem2proc.data <= 64'd0;
    end
    mem2proc.response <= ($urandom % 4 != 0) ? next_tag : 4'd0;
endtask

//--- sim/dmem_tb.sv
`timescale 1ns/1ns
// testbench: clock, reset, seeded random load/store traffic, model checks and timeout
module dmem_tb;

    localparam int n_ops      = 600;
    localparam int n_random   = 588;
    localparam int max_cycles = 40 * n_ops;

    logic                          clock, rst_n, except, commit;
    dmem_pkg::ls_req_t             req;
    dmem_pkg::mem_rsp_t            mem2proc;
    logic [dmem_pkg::sq_cnt_w-1:0] sq_num_free;
    logic                          lq_num_free;
    dmem_pkg::cdb_pkt_t            cdb_out;
    dmem_pkg::mem_cmd_e            dmem_cmd;
    logic [15:0]                   dmem_addr;
    dmem_pkg::mem_size_e           dmem_size;
    logic [63:0]                   dmem_data;

    dmem_pkg::ls_req_t  ops [n_ops];
    logic               serial [n_ops];
    logic               no_read [n_ops];
    dmem_pkg::mem_req_t sq_model [$];
    dmem_pkg::ls_req_t  ld_ent;
    logic               ld_pending, ld_no_read;
    int                 n_comm, commit_ok, next_op, cycle, reads, ld_reads;

    `include "dmem_ref.svh"

    dmem UUT (
        .clock, .rst_n, .except, .commit, .req, .mem2proc, .sq_num_free, .lq_num_free,
        .cdb_out, .dmem_cmd, .dmem_addr, .dmem_size, .dmem_data
    );

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_pkt(input dmem_pkg::cdb_pkt_t want, input dmem_pkg::cdb_pkt_t got);
        if (got !== want) begin
            fail_run($sformatf("CHECK FAILED at %0t: cdb data %h prf %0d rob %0d, want %h %0d %0d",
                $time, got.data, got.prf_idx, got.rob_idx, want.data, want.prf_idx,
                want.rob_idx));
        end
    endtask

    task automatic check_store(input dmem_pkg::mem_req_t want, input dmem_pkg::mem_req_t got);
        if (got !== want) begin
            fail_run($sformatf("CHECK FAILED at %0t: store addr %h size %0d data %h, want %h %0d %h",
                $time, got.addr, got.size, got.data, want.addr, want.size, want.data));
        end
    endtask

    task automatic check_free(input logic [dmem_pkg::sq_cnt_w-1:0] want_sq, got_sq,
                              input logic want_lq, got_lq);
        if (got_sq !== want_sq || got_lq !== want_lq) begin
            fail_run($sformatf("CHECK FAILED at %0t: free sq %0d lq %0d, want sq %0d lq %0d",
                $time, got_sq, got_lq, want_sq, want_lq));
        end
    endtask

    // 16 lines, two tags per set, aligned accesses
    function automatic dmem_pkg::ls_req_t random_op();
        dmem_pkg::ls_req_t op;
        logic [3:0]        line;
        logic [2:0]        off;
        op           = '0;
        op.valid     = 1'b1;
        op.is_load   = ($urandom % 5) < 2;
        op.size      = dmem_pkg::mem_size_e'(2'($urandom % 3));
        line         = 4'($urandom);
        off          = 3'($urandom) & ~3'((1 << int'(op.size)) - 1);
        op.addr      = {7'b0, line[3], 2'b0, line[2:0], off};
        op.is_signed = 1'($urandom);
        op.data      = $urandom;
        op.rob_idx   = 5'($urandom);
        op.prf_idx   = 6'($urandom);
        return op;
    endfunction

    function automatic logic room_for(input int i);
        if (serial[i] && (sq_model.size() != 0 || ld_pending || rd_busy)) begin
            return 1'b0;
        end
        if (ops[i].is_load) begin
            return !ld_pending;
        end
        return sq_model.size() < dmem_pkg::sq_depth;
    endfunction

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        void'($urandom(32'h8990_1cfc));
        rst_n = 1'b0;
        except = 1'b0;
        commit = 1'b0;
        req = '0;
        mem2proc = '0;
        fill_image();
        next_tag = 4'd1;
        rd_busy = 1'b0;
        ld_pending = 1'b0;
        ld_no_read = 1'b0;
        n_comm = 0;
        commit_ok = 0;
        next_op = 0;
        cycle = 0;
        reads = 0;
        ld_reads = 0;
        for (int i = 0; i < n_ops; i++) begin
            ops[i] = random_op();
            serial[i] = i >= n_random;
            no_read[i] = 1'b0;
        end
        // per line: load, reload, byte store, reload after the store
        for (int k = 0; k < 3; k++) begin
            for (int j = 0; j < 4; j++) begin
                ops[n_random + 4*k + j].is_load   = j != 2;
                ops[n_random + 4*k + j].size      = (j == 1) ? dmem_pkg::mem_half :
                                                    (j == 2) ? dmem_pkg::mem_byte :
                                                    dmem_pkg::mem_word;
                ops[n_random + 4*k + j].addr      = 16'(k * 8 + ((j == 1) ? 2 : (j == 2) ? 1 : 0));
                ops[n_random + 4*k + j].is_signed = j == 1;
                no_read[n_random + 4*k + j]       = j == 1 || j == 3;
            end
        end
        repeat (8) @(posedge clock);
        rst_n <= 1'b1;
    end

    always @(posedge clock) begin : monitor
        dmem_pkg::cdb_pkt_t want;
        dmem_pkg::mem_req_t seen;
        if (rst_n) begin
            cycle++;
            if (cycle > max_cycles) begin
                fail_run($sformatf("timeout: run did not finish within %0d cycles", max_cycles));
            end
            if (cycle == 1 && (dmem_cmd != dmem_pkg::cmd_none || cdb_out.valid)) begin
                fail_run("memory command or bus valid was active right after reset");
            end
            check_free(dmem_pkg::sq_cnt_w'(dmem_pkg::sq_depth - sq_model.size()), sq_num_free,
                       !ld_pending, lq_num_free);
            if (cdb_out.valid) begin
                if (!ld_pending) begin
                    fail_run("bus packet arrived with no load pending");
                end
                want = '{valid: 1'b1, data: predict_load(ld_ent),
                         prf_idx: ld_ent.prf_idx, rob_idx: ld_ent.rob_idx};
                check_pkt(want, cdb_out);
                if (ld_no_read && reads != ld_reads) begin
                    fail_run("load to a line already cached read memory again");
                end
                ld_pending = 1'b0;
                commit_ok = sq_model.size() - n_comm;
            end
            if (dmem_cmd != dmem_pkg::cmd_none && mem2proc.response != 4'd0) begin
                seen = '{cmd: dmem_cmd, addr: dmem_addr, size: dmem_size, data: dmem_data};
                if (dmem_cmd == dmem_pkg::cmd_store) begin
                    if (n_comm == 0) begin
                        fail_run("store reached memory before it was committed");
                    end
                    check_store(sq_model[0], seen);
                    apply_store(seen);
                    void'(sq_model.pop_front());
                    n_comm--;
                end else begin
                    if (rd_busy) begin
                        fail_run("second memory read issued while one was outstanding");
                    end
                    reads++;
                    take_read(dmem_addr, cycle);
                end
                next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
            if (req.valid && req.is_load) begin
                ld_pending = 1'b1;
                ld_ent = req;
            end else if (req.valid) begin
                sq_model.push_back('{cmd: dmem_pkg::cmd_store, addr: req.addr, size: req.size,
                                     data: {32'b0, req.data}});
                if (!ld_pending) begin
                    commit_ok++;
                end
            end
            if (commit) begin
                n_comm++;
                commit_ok--;
            end
            // flush drops the load and everything the ROB has not retired
            if (except) begin
                ld_pending = 1'b0;
                while (sq_model.size() > n_comm) begin
                    void'(sq_model.pop_back());
                end
                commit_ok = 0;
            end
            respond_step(cycle);

            req    <= '0;
            commit <= 1'b0;
            except <= 1'b0;
            if (next_op >= n_ops) begin
                if (sq_model.size() == 0 && !ld_pending && !rd_busy) begin
                    $display("No errors");
                    $finish;
                end else if (commit_ok > 0) begin
                    commit <= 1'b1;
                end
            end else if (next_op < n_random && $urandom % 50 == 0) begin
                except <= 1'b1;
            end else begin
                if (commit_ok > 0 && $urandom % 3 == 0) begin
                    commit <= 1'b1;
                end
                if (room_for(next_op)) begin
                    req <= ops[next_op];
                    if (ops[next_op].is_load) begin
                        ld_no_read = no_read[next_op];
                        ld_reads = reads;
                    end
                    next_op++;
                end
            end
        end
    end

endmodule

//--- all.f
+incdir+sim
logic/dmem_pkg.sv
logic/store_queue.sv
logic/load_unit.sv
logic/dcache.sv
logic/dcache_ctrl.sv
logic/dmem.sv
sim/dmem_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := dmem_tb
FILELIST  := all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
